// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

  // geometry
  localparam int addr_width = 32;
  localparam int data_width = 64;
  localparam int num_sets = 32;
  localparam int index_width = 5;
  localparam int tag_width = 24;
  localparam int offset_width = addr_width - tag_width - index_width;

  // core side
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
  } ld_req_t;

  typedef struct packed {
    logic                  done;
    logic [data_width-1:0] data;
  } ld_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } st_req_t;

  typedef struct packed {
    logic done;
  } st_rsp_t;

  // wishbone classic, master outputs and slave outputs
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [addr_width-1:0] adr;
    logic [data_width-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic [data_width-1:0] dat;
  } wb_rsp_t;

  // between controller, array and miss handler
  typedef struct packed {
    logic                   en;
    logic [index_width-1:0] index;
    logic [tag_width-1:0]   tag;
    logic [data_width-1:0]  data;
    logic                   dirty;
  } array_wr_t;

  typedef struct packed {
    logic                  valid;
    logic                  dirty;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } victim_t;

  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    logic                  wb_needed;
    logic [addr_width-1:0] wb_addr;
    logic [data_width-1:0] wb_data;
  } miss_req_t;

  typedef struct packed {
    logic                  done;
    logic [data_width-1:0] data;
  } miss_rsp_t;

endpackage

// ==== logic/dcache_array.sv ====
`timescale 1ns/10ps

module dcache_array (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic [dcache_pkg::index_width-1:0]     lookup_index,
  input  logic [dcache_pkg::tag_width-1:0]       lookup_tag,
  input  dcache_pkg::array_wr_t                  array_wr,
  output logic                                   hit,
  output logic [dcache_pkg::data_width-1:0]      rd_data,
  output dcache_pkg::victim_t                    victim
);
  import dcache_pkg::*;

  logic [tag_width-1:0]   tag_mem  [num_sets];
  logic [data_width-1:0]  data_mem [num_sets];
  logic [num_sets-1:0]    valid_bits;
  logic [num_sets-1:0]    dirty_bits;

  // registered copy of the resident line
  logic                   vic_valid;
  logic                   vic_dirty;
  logic [tag_width-1:0]   vic_tag;
  logic [index_width-1:0] vic_index;
  logic [data_width-1:0]  vic_data;

  always_ff @(posedge clock) begin
    if (array_wr.en) begin
      tag_mem[array_wr.index]  <= array_wr.tag;
      data_mem[array_wr.index] <= array_wr.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (array_wr.en) begin
      valid_bits[array_wr.index] <= 1'b1;
      dirty_bits[array_wr.index] <= array_wr.dirty;
    end
  end

  // lookup result, one cycle after the index
  always_ff @(posedge clock) begin
    if (reset) begin
      hit       <= 1'b0;
      vic_valid <= 1'b0;
      vic_dirty <= 1'b0;
    end else begin
      hit       <= valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
      vic_valid <= valid_bits[lookup_index];
      vic_dirty <= dirty_bits[lookup_index];
    end
  end

  always_ff @(posedge clock) begin
    rd_data   <= data_mem[lookup_index];
    vic_tag   <= tag_mem[lookup_index];
    vic_index <= lookup_index;
    vic_data  <= data_mem[lookup_index];
  end

  // victim address rebuilt from stored tag and set index
  assign victim.valid = vic_valid;
  assign victim.dirty = vic_dirty;
  assign victim.addr  = {vic_tag, vic_index, {offset_width{1'b0}}};
  assign victim.data  = vic_data;

endmodule

// ==== logic/miss_handler.sv ====
`timescale 1ns/10ps

module miss_handler (
  input  logic                   clock,
  input  logic                   reset,
  input  dcache_pkg::miss_req_t  miss_req,
  output dcache_pkg::miss_rsp_t  miss_rsp,
  output dcache_pkg::wb_req_t    wb_req,
  input  dcache_pkg::wb_rsp_t    wb_rsp
);
  import dcache_pkg::*;

  typedef enum logic [1:0] {
    idle,
    writeback,
    fetch
  } state_t;

  state_t                state;
  logic                  cyc;
  logic                  we;
  logic [addr_width-1:0] adr;
  logic [data_width-1:0] dat;
  logic                  bus_ack;

  // classic bus, stb follows cyc
  assign wb_req.cyc = cyc;
  assign wb_req.stb = cyc;
  assign wb_req.we  = we;
  assign wb_req.adr = adr;
  assign wb_req.dat = dat;

  assign bus_ack = cyc && wb_rsp.ack;

  // fill goes straight back in the ack cycle
  assign miss_rsp.done = (state == fetch) && bus_ack;
  assign miss_rsp.data = wb_rsp.dat;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      cyc   <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (miss_req.valid) begin
            cyc <= 1'b1;
            if (miss_req.wb_needed) begin
              state <= writeback;
            end else begin
              state <= fetch;
            end
          end
        end
        writeback: begin
          // drop cyc for a cycle between the two transfers
          if (bus_ack) begin
            cyc   <= 1'b0;
            state <= fetch;
          end
        end
        fetch: begin
          if (bus_ack) begin
            cyc   <= 1'b0;
            state <= idle;
          end else if (!cyc) begin
            cyc <= 1'b1;
          end
        end
        default: begin
          cyc   <= 1'b0;
          state <= idle;
        end
      endcase
    end
  end

  // address, direction and write data
  always_ff @(posedge clock) begin
    if (state == idle && miss_req.valid) begin
      we  <= miss_req.wb_needed;
      adr <= miss_req.wb_needed ? miss_req.wb_addr : miss_req.addr;
      dat <= miss_req.wb_data;
    end else if (state == writeback && bus_ack) begin
      we  <= 1'b0;
      adr <= miss_req.addr;
    end
  end

endmodule

// ==== logic/dcache_controller.sv ====
`timescale 1ns/10ps

module dcache_controller (
  input  logic                               clock,
  input  logic                               reset,
  input  dcache_pkg::ld_req_t                ld_req,
  input  dcache_pkg::st_req_t                st_req,
  input  logic                               flush,
  output dcache_pkg::ld_rsp_t                ld_rsp,
  output dcache_pkg::st_rsp_t                st_rsp,
  output logic                               flush_done,
  output logic [dcache_pkg::index_width-1:0] lookup_index,
  output logic [dcache_pkg::tag_width-1:0]   lookup_tag,
  input  logic                               hit,
  input  logic [dcache_pkg::data_width-1:0]  rd_data,
  input  dcache_pkg::victim_t                victim,
  output dcache_pkg::array_wr_t              array_wr,
  output dcache_pkg::miss_req_t              miss_req,
  input  dcache_pkg::miss_rsp_t              miss_rsp
);
  import dcache_pkg::*;

  typedef enum logic [2:0] {
    idle, lookup, miss_wait, flush_scan, flush_wait, flushed
  } state_t;

  typedef enum logic [2:0] {
    grant_none, grant_flush, grant_fill, grant_store, grant_load
  } grant_t;

  state_t                 state;
  grant_t                 grant;
  logic                   serve_store;
  logic                   flush_pending;
  logic [index_width-1:0] flush_count;
  logic                   scan_valid;
  logic                   ld_done;
  logic                   st_done;
  logic [data_width-1:0]  ld_data;
  logic                   miss_valid;
  logic [addr_width-1:0]  miss_addr;
  logic                   miss_wb_needed;
  logic [addr_width-1:0]  miss_wb_addr;
  logic [data_width-1:0]  miss_wb_data;
  logic [addr_width-1:0]  port_addr;
  logic [index_width-1:0] scan_index;
  logic [index_width-1:0] miss_index;
  logic                   scan_dirty;
  logic                   start_miss;

  assign ld_rsp   = '{done: ld_done, data: ld_data};
  assign st_rsp   = '{done: st_done};
  assign miss_req = '{valid: miss_valid, addr: miss_addr, wb_needed: miss_wb_needed,
                      wb_addr: miss_wb_addr, wb_data: miss_wb_data};

  // one owner of the array per cycle: flush, fill, store, load
  always_comb begin
    grant = grant_none;
    if (state == flush_scan || state == flush_wait ||
        ((state == idle || state == flushed) && (flush || flush_pending))) begin
      grant = grant_flush;
    end else if (state == miss_wait) begin
      grant = grant_fill;
    end else if (state == lookup) begin
      grant = serve_store ? grant_store : grant_load;
    end else if (st_req.valid && !st_done) begin
      grant = grant_store;
    end else if (ld_req.valid && !ld_done) begin
      grant = grant_load;
    end
  end

  assign port_addr    = (grant == grant_store) ? st_req.addr : ld_req.addr;
  assign lookup_index = (grant == grant_flush) ? flush_count
                                               : port_addr[offset_width +: index_width];
  assign lookup_tag   = port_addr[addr_width-1 -: tag_width];

  // victim index doubles as the index being scanned
  assign scan_index = victim.addr[offset_width +: index_width];
  assign miss_index = miss_addr[offset_width +: index_width];
  assign scan_dirty = scan_valid && victim.valid && victim.dirty;
  assign start_miss = (state == lookup && !hit) || (state == flush_scan && scan_dirty);

  always_comb begin
    array_wr.en    = 1'b0;
    array_wr.index = miss_index;
    array_wr.tag   = miss_addr[addr_width-1 -: tag_width];
    array_wr.data  = miss_rsp.data;
    array_wr.dirty = 1'b0;
    if (state == lookup && grant == grant_store && hit) begin
      array_wr.en    = 1'b1;
      array_wr.index = st_req.addr[offset_width +: index_width];
      array_wr.tag   = st_req.addr[addr_width-1 -: tag_width];
      array_wr.data  = st_req.data;
      array_wr.dirty = 1'b1;
    end else if ((grant == grant_fill || grant == grant_flush) && miss_rsp.done) begin
      array_wr.en = 1'b1;
      // store miss merges its word over the fill
      if (grant == grant_fill && serve_store) begin
        array_wr.data  = st_req.data;
        array_wr.dirty = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= idle;
      serve_store   <= 1'b0;
      flush_pending <= 1'b0;
      flush_done    <= 1'b0;
      flush_count   <= '0;
      scan_valid    <= 1'b0;
      ld_done       <= 1'b0;
      st_done       <= 1'b0;
      miss_valid    <= 1'b0;
    end else begin
      ld_done <= 1'b0;
      st_done <= 1'b0;
      if (flush) begin
        flush_pending <= 1'b1;
        flush_done    <= 1'b0;
      end
      case (state)
        idle, flushed: begin
          if (grant == grant_flush) begin
            state         <= flush_scan;
            flush_pending <= 1'b0;
            flush_done    <= 1'b0;
            flush_count   <= '0;
            scan_valid    <= 1'b0;
          end else if (grant == grant_store || grant == grant_load) begin
            state       <= lookup;
            serve_store <= (grant == grant_store);
          end
        end
        lookup: begin
          if (hit) begin
            st_done <= serve_store;
            ld_done <= !serve_store;
            state   <= idle;
          end else begin
            miss_valid <= 1'b1;
            state      <= miss_wait;
          end
        end
        miss_wait: begin
          if (miss_rsp.done) begin
            miss_valid <= 1'b0;
            st_done    <= serve_store;
            ld_done    <= !serve_store;
            state      <= idle;
          end
        end
        flush_scan: begin
          // one set per cycle, stop on a dirty line
          if (scan_dirty) begin
            miss_valid <= 1'b1;
            scan_valid <= 1'b0;
            state      <= flush_wait;
          end else if (scan_valid && scan_index == index_width'(num_sets - 1)) begin
            flush_done <= 1'b1;
            state      <= flushed;
          end else begin
            flush_count <= flush_count + 1'b1;
            scan_valid  <= 1'b1;
          end
        end
        flush_wait: begin
          if (miss_rsp.done) begin
            miss_valid <= 1'b0;
            if (miss_index == index_width'(num_sets - 1)) begin
              flush_done <= 1'b1;
              state      <= flushed;
            end else begin
              flush_count <= miss_index + 1'b1;
              state       <= flush_scan;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // load data and miss request payload
  always_ff @(posedge clock) begin
    if (state == lookup && hit) begin
      ld_data <= rd_data;
    end else if (state == miss_wait && miss_rsp.done) begin
      ld_data <= miss_rsp.data;
    end
    if (start_miss) begin
      // a flush refetches the written line itself
      miss_addr      <= (state == flush_scan) ? victim.addr : port_addr;
      miss_wb_needed <= victim.valid && victim.dirty;
      miss_wb_addr   <= victim.addr;
      miss_wb_data   <= victim.data;
    end
  end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top (
  input  logic                 clock,
  input  logic                 reset,
  input  dcache_pkg::ld_req_t  ld_req,
  input  dcache_pkg::st_req_t  st_req,
  input  logic                 flush,
  output dcache_pkg::ld_rsp_t  ld_rsp,
  output dcache_pkg::st_rsp_t  st_rsp,
  output logic                 flush_done,
  output dcache_pkg::wb_req_t  wb_req,
  input  dcache_pkg::wb_rsp_t  wb_rsp
);
  import dcache_pkg::*;

  logic [index_width-1:0] lookup_index;
  logic [tag_width-1:0]   lookup_tag;
  logic                   hit;
  logic [data_width-1:0]  rd_data;
  victim_t                victim;
  array_wr_t              array_wr;
  miss_req_t              miss_req;
  miss_rsp_t              miss_rsp;

  dcache_controller controller_i (
    .clock        (clock),
    .reset        (reset),
    .ld_req       (ld_req),
    .st_req       (st_req),
    .flush        (flush),
    .ld_rsp       (ld_rsp),
    .st_rsp       (st_rsp),
    .flush_done   (flush_done),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .hit          (hit),
    .rd_data      (rd_data),
    .victim       (victim),
    .array_wr     (array_wr),
    .miss_req     (miss_req),
    .miss_rsp     (miss_rsp)
  );

  dcache_array array_i (
    .clock        (clock),
    .reset        (reset),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .array_wr     (array_wr),
    .hit          (hit),
    .rd_data      (rd_data),
    .victim       (victim)
  );

  miss_handler miss_handler_i (
    .clock    (clock),
    .reset    (reset),
    .miss_req (miss_req),
    .miss_rsp (miss_rsp),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp)
  );

endmodule

// ==== testbench/wb_mem_model.sv ====
`timescale 1ns/10ps

module wb_mem_model #(
  parameter logic [63:0] fill_key  = 64'h0,
  parameter int          mem_words = 1024
) (
  input  logic                 clock,
  input  logic                 reset,
  input  dcache_pkg::wb_req_t  wb_req,
  output dcache_pkg::wb_rsp_t  wb_rsp,
  input  logic [31:0]          peek_addr,
  output logic [63:0]          peek_data
);
  import dcache_pkg::*;

  localparam int word_bits = $clog2(mem_words);

  logic [data_width-1:0] mem [mem_words];
  logic                  busy;
  logic [1:0]            wait_count;
  logic [addr_width-1:0] fill_addr;

  // every word starts as a pattern of its full byte address
  initial begin
    for (int i = 0; i < mem_words; i++) begin
      fill_addr = addr_width'(i * 8);
      mem[i] = {~fill_addr, fill_addr} ^ fill_key;
    end
  end

  // backdoor read for the testbench
  assign peek_data = mem[peek_addr[3 +: word_bits]];

  always @(posedge clock) begin
    if (reset) begin
      wb_rsp.ack <= 1'b0;
      busy       <= 1'b0;
      wait_count <= '0;
    end else begin
      wb_rsp.ack <= 1'b0;
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (!busy) begin
          // random stall of 0 to 3 cycles
          busy       <= 1'b1;
          wait_count <= 2'($urandom % 4);
        end else if (wait_count != 2'd0) begin
          wait_count <= wait_count - 1'b1;
        end else begin
          busy       <= 1'b0;
          wb_rsp.ack <= 1'b1;
          wb_rsp.dat <= mem[wb_req.adr[3 +: word_bits]];
          if (wb_req.we) begin
            mem[wb_req.adr[3 +: word_bits]] <= wb_req.dat;
          end
        end
      end
    end
  end

endmodule

// ==== testbench/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;
  import dcache_pkg::*;

  localparam logic [63:0] fill_key       = 64'h5a3c_96e1_0f78_c3a5;
  localparam int          mem_words      = 1024;
  localparam int          word_bits      = $clog2(mem_words);
  localparam int          timeout_cycles = 200;
  localparam int          num_tests      = 18;

  typedef enum logic [2:0] {
    op_load, op_store, op_both, op_flush, op_mem_check
  } op_t;

  // quiet marks a load that must hit without any bus cycle
  typedef struct packed {
    op_t                   op;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic                  quiet;
  } test_entry_t;

  logic                  clock;
  logic                  reset;
  ld_req_t               ld_req;
  st_req_t               st_req;
  logic                  flush;
  ld_rsp_t               ld_rsp;
  st_rsp_t               st_rsp;
  logic                  flush_done;
  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;
  logic [addr_width-1:0] peek_addr;
  logic [data_width-1:0] peek_data;

  test_entry_t           tests [num_tests];
  logic [data_width-1:0] ref_mem [mem_words];
  logic [addr_width-1:0] stored_addrs [$];
  int                    bus_cycles;
  int                    errors;
  int                    passed;
  int                    tests_run;
  bit                    timed_out;

  dcache_top dut_i (
    .clock      (clock),
    .reset      (reset),
    .ld_req     (ld_req),
    .st_req     (st_req),
    .flush      (flush),
    .ld_rsp     (ld_rsp),
    .st_rsp     (st_rsp),
    .flush_done (flush_done),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp)
  );

  wb_mem_model #(
    .fill_key  (fill_key),
    .mem_words (mem_words)
  ) mem_i (
    .clock     (clock),
    .reset     (reset),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .peek_addr (peek_addr),
    .peek_data (peek_data)
  );

  always #5 clock = ~clock;

  // cycles with the bus owned by the cache
  always @(posedge clock) begin
    if (reset) begin
      bus_cycles <= 0;
    end else if (wb_req.cyc) begin
      bus_cycles <= bus_cycles + 1;
    end
  end

  function automatic logic [word_bits-1:0] word_index(input logic [addr_width-1:0] addr);
    return addr[3 +: word_bits];
  endfunction

  task automatic init_reference();
    logic [addr_width-1:0] a;
    for (int i = 0; i < mem_words; i++) begin
      a = addr_width'(i * 8);
      ref_mem[i] = {~a, a} ^ fill_key;
    end
  endtask

  // A = 0x080 and A + 256 share set 16
  task automatic build_table();
    tests[0]  = '{op_load,      32'h0000_0040, 64'h0, 1'b0};
    tests[1]  = '{op_load,      32'h0000_0040, 64'h0, 1'b1};
    tests[2]  = '{op_store,     32'h0000_0048, 64'h1111_2222_3333_4444, 1'b0};
    tests[3]  = '{op_load,      32'h0000_0048, 64'h0, 1'b1};
    tests[4]  = '{op_store,     32'h0000_0040, 64'hdead_beef_0bad_f00d, 1'b0};
    tests[5]  = '{op_load,      32'h0000_0040, 64'h0, 1'b1};
    tests[6]  = '{op_store,     32'h0000_0080, 64'h0123_4567_89ab_cdef, 1'b0};
    tests[7]  = '{op_load,      32'h0000_0180, 64'h0, 1'b0};
    tests[8]  = '{op_mem_check, 32'h0000_0080, 64'h0, 1'b0};
    tests[9]  = '{op_load,      32'h0000_0080, 64'h0, 1'b0};
    tests[10] = '{op_both,      32'h0000_00c0, 64'hcafe_0000_face_0001, 1'b0};
    tests[11] = '{op_store,     32'h0000_0100, 64'h5555_aaaa_5555_aaaa, 1'b0};
    tests[12] = '{op_store,     32'h0000_0108, 64'h0f0f_0f0f_f0f0_f0f0, 1'b0};
    tests[13] = '{op_store,     32'h0000_0110, 64'h7777_8888_9999_0000, 1'b0};
    tests[14] = '{op_store,     32'h0000_0118, 64'h1357_9bdf_2468_ace0, 1'b0};
    tests[15] = '{op_flush,     32'h0000_0000, 64'h0, 1'b0};
    tests[16] = '{op_load,      32'h0000_0110, 64'h0, 1'b1};
    tests[17] = '{op_load,      32'h0000_00c0, 64'h0, 1'b1};
  endtask

  task automatic report_test(input int n, input string kind, input logic [31:0] addr,
                             input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      passed++;
      $display("test %0d %s %08h: ok", n, kind, addr);
    end else begin
      $display("test %0d %s %08h: error", n, kind, addr);
    end
  endtask

  task automatic record_store(input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] data);
    ref_mem[word_index(addr)] = data;
    stored_addrs.push_back(addr);
  endtask

  task automatic compare_memory(input int n, input logic [addr_width-1:0] addr);
    peek_addr = addr;
    #1;
    if (peek_data !== ref_mem[word_index(addr)]) begin
      $display("Mismatch at %0t: test %0d, memory at %08h holds %016h, expected %016h",
               $time, n, addr, peek_data, ref_mem[word_index(addr)]);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    int errors_before;
    errors_before = errors;
    if (ld_rsp.done || st_rsp.done || flush_done || wb_req.cyc || wb_req.stb) begin
      $display("Error at %0t: outputs are not idle after reset", $time);
      errors++;
    end
    report_test(0, "reset", 32'h0, errors_before);
  endtask

  task automatic run_load(input int n, input logic [addr_width-1:0] addr, input logic quiet);
    logic [data_width-1:0] expected;
    int                    start_bus;
    int                    cycles;
    int                    errors_before;
    errors_before = errors;
    expected = ref_mem[word_index(addr)];
    start_bus = bus_cycles;
    ld_req = '{valid: 1'b1, addr: addr};
    cycles = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
    end while (!ld_rsp.done && cycles < timeout_cycles);
    ld_req = '0;
    if (!ld_rsp.done) begin
      $display("Timeout at %0t: test %0d, load of %08h got no done in %0d cycles",
               $time, n, addr, timeout_cycles);
      errors++;
      timed_out = 1'b1;
    end else if (ld_rsp.data !== expected) begin
      $display("Mismatch at %0t: test %0d, load of %08h returned %016h, expected %016h",
               $time, n, addr, ld_rsp.data, expected);
      errors++;
    end
    if (quiet && bus_cycles != start_bus) begin
      $display("Error at %0t: test %0d, load of %08h should hit but used the bus",
               $time, n, addr);
      errors++;
    end
    report_test(n, "load", addr, errors_before);
  endtask

  task automatic run_store(input int n, input logic [addr_width-1:0] addr,
                           input logic [data_width-1:0] data);
    int cycles;
    int errors_before;
    errors_before = errors;
    st_req = '{valid: 1'b1, addr: addr, data: data};
    cycles = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
    end while (!st_rsp.done && cycles < timeout_cycles);
    st_req = '0;
    if (!st_rsp.done) begin
      $display("Timeout at %0t: test %0d, store to %08h got no done in %0d cycles",
               $time, n, addr, timeout_cycles);
      errors++;
      timed_out = 1'b1;
    end else begin
      record_store(addr, data);
    end
    report_test(n, "store", addr, errors_before);
  endtask

  // store and load raised together with the store served first
  task automatic run_both(input int n, input logic [addr_width-1:0] addr,
                          input logic [data_width-1:0] data);
    logic [data_width-1:0] got;
    logic                  ld_seen;
    logic                  st_seen;
    logic                  order_ok;
    int                    cycles;
    int                    errors_before;
    errors_before = errors;
    st_req = '{valid: 1'b1, addr: addr, data: data};
    ld_req = '{valid: 1'b1, addr: addr};
    ld_seen = 1'b0;
    st_seen = 1'b0;
    order_ok = 1'b1;
    got = '0;
    cycles = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
      if (st_rsp.done) begin
        st_seen = 1'b1;
        st_req = '0;
        record_store(addr, data);
      end
      if (ld_rsp.done) begin
        ld_seen = 1'b1;
        ld_req = '0;
        got = ld_rsp.data;
        order_ok = st_seen;
      end
    end while (!(ld_seen && st_seen) && cycles < timeout_cycles);
    st_req = '0;
    ld_req = '0;
    if (!(ld_seen && st_seen)) begin
      $display("Timeout at %0t: test %0d, load and store at %08h not both done in %0d cycles",
               $time, n, addr, timeout_cycles);
      errors++;
      timed_out = 1'b1;
    end else if (!order_ok) begin
      $display("Error at %0t: test %0d, load finished before the store", $time, n);
      errors++;
    end else if (got !== ref_mem[word_index(addr)]) begin
      $display("Mismatch at %0t: test %0d, load of %08h returned %016h, expected %016h",
               $time, n, addr, got, ref_mem[word_index(addr)]);
      errors++;
    end
    report_test(n, "load+store", addr, errors_before);
  endtask

  task automatic run_flush(input int n);
    int cycles;
    int errors_before;
    errors_before = errors;
    flush = 1'b1;
    @(posedge clock);
    #1;
    flush = 1'b0;
    cycles = 0;
    while (!flush_done && cycles < timeout_cycles) begin
      @(posedge clock);
      #1;
      cycles++;
    end
    if (!flush_done) begin
      $display("Timeout at %0t: test %0d, flush_done did not rise in %0d cycles",
               $time, n, timeout_cycles);
      errors++;
      timed_out = 1'b1;
    end else begin
      // every stored word must now sit in memory
      foreach (stored_addrs[k]) begin
        compare_memory(n, stored_addrs[k]);
      end
    end
    report_test(n, "flush", 32'h0, errors_before);
  endtask

  task automatic run_mem_check(input int n, input logic [addr_width-1:0] addr);
    int errors_before;
    errors_before = errors;
    compare_memory(n, addr);
    report_test(n, "memory", addr, errors_before);
  endtask

  task automatic run_test(input int n, input test_entry_t t);
    case (t.op)
      op_load:  run_load(n, t.addr, t.quiet);
      op_store: run_store(n, t.addr, t.data);
      op_both:  run_both(n, t.addr, t.data);
      op_flush: run_flush(n);
      default:  run_mem_check(n, t.addr);
    endcase
  endtask

  task automatic finish_run();
    $display("%0d tests, %0d passed, %0d errors", tests_run, passed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'hbc3caf27));
    clock = 1'b0;
    reset = 1'b1;
    ld_req = '0;
    st_req = '0;
    flush = 1'b0;
    peek_addr = '0;
    errors = 0;
    passed = 0;
    tests_run = 0;
    timed_out = 1'b0;
    init_reference();
    build_table();
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    check_reset_state();
    for (int i = 0; i < num_tests && !timed_out; i++) begin
      @(posedge clock);
      #1;
      run_test(i + 1, tests[i]);
    end
    finish_run();
  end

endmodule

// ==== compile.f ====
logic/dcache_pkg.sv
logic/dcache_array.sv
logic/miss_handler.sv
logic/dcache_controller.sv
logic/dcache_top.sv
testbench/wb_mem_model.sv
testbench/dcache_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --timescale 1ns/10ps
SIM_FLAGS  = --binary --timing --timescale 1ns/10ps -j 0
TOP        = dcache_tb
FILELIST   = compile.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Result: FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
